/* src/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import rv_pkg::*; (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_instr,
  input  logic            i_valid,
  input  logic            i_bubble,
  input  logic            i_flush,
  id_ex_if.decode         id_ex,
  mem_wb_if.writeback     mem_wb
);

  opcode_e           opcode;
  logic [2:0]        funct3;
  logic              alt;
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [REG_AW-1:0] rd;
  logic [XLEN-1:0]   imm_i;
  logic [XLEN-1:0]   imm_s;
  logic [XLEN-1:0]   imm_b;
  logic [XLEN-1:0]   imm_u;
  logic [XLEN-1:0]   imm_j;
  logic [XLEN-1:0]   rs1_data;
  logic [XLEN-1:0]   rs2_data;

  logic              known;
  logic              dec_valid;
  logic [XLEN-1:0]   imm;
  logic              rd_wren;
  alu_op_e           alu_op;
  logic              opa_pc;
  logic              opb_imm;
  logic              branch;
  logic              jump;
  logic              mem_wren;
  logic              mem_rden;
  wb_sel_e           wb_sel;

  // funct3 and funct7 bit 30 select the alu op
  // sub exists only in register form
  function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic f7_alt,
                                         input logic is_reg);
    case (f3)
      3'b000:  return (is_reg && f7_alt) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return f7_alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = opcode_e'(i_instr[OPCODE_LSB +: OPCODE_W]);
  assign funct3 = i_instr[FUNCT3_LSB +: FUNCT3_W];
  assign alt    = i_instr[F7_ALT_BIT];
  assign rs1    = i_instr[RS1_LSB +: REG_AW];
  assign rs2    = i_instr[RS2_LSB +: REG_AW];
  assign rd     = i_instr[RD_LSB +: REG_AW];

  assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
  assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
  assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                  i_instr[11:8], 1'b0};
  assign imm_u = {i_instr[31:12], 12'b0};
  assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                  i_instr[30:21], 1'b0};

  always_comb begin
    known    = 1'b1;
    imm      = imm_i;
    rd_wren  = 1'b0;
    alu_op   = ALU_ADD;
    opa_pc   = 1'b0;
    opb_imm  = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    mem_wren = 1'b0;
    mem_rden = 1'b0;
    wb_sel   = WB_ALU;
    case (opcode)
      OPC_OP: begin
        rd_wren = 1'b1;
        alu_op  = alu_decode(funct3, alt, 1'b1);
      end
      OPC_OP_IMM: begin
        rd_wren = 1'b1;
        opb_imm = 1'b1;
        alu_op  = alu_decode(funct3, alt, 1'b0);
      end
      OPC_LUI: begin
        rd_wren = 1'b1;
        opb_imm = 1'b1;
        imm     = imm_u;
        alu_op  = ALU_PASS_B;
      end
      OPC_LOAD: begin
        rd_wren  = 1'b1;
        opb_imm  = 1'b1;
        mem_rden = 1'b1;
        wb_sel   = WB_LOAD;
      end
      OPC_STORE: begin
        opb_imm  = 1'b1;
        imm      = imm_s;
        mem_wren = 1'b1;
      end
      OPC_BRANCH: begin
        imm    = imm_b;
        branch = 1'b1;
      end
      OPC_JAL: begin
        rd_wren = 1'b1;
        opa_pc  = 1'b1;
        opb_imm = 1'b1;
        imm     = imm_j;
        jump    = 1'b1;
        wb_sel  = WB_PC4;
      end
      default: known = 1'b0;
    endcase
  end

  // unknown opcodes die here
  assign dec_valid = i_valid && known;

  regfile u_regfile (
    .i_clk      (i_clk),
    .i_rs1_addr (rs1),
    .i_rs2_addr (rs2),
    .i_rd_addr  (mem_wb.rd),
    .i_rd_wren  (mem_wb.rd_wren),
    .i_rd_data  (mem_wb.wdata),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  // ID/EX control bits that bubble and flush clear
  always_ff @(posedge i_clk) begin
    if (!i_rst_n || i_bubble || i_flush) begin
      id_ex.valid    <= 1'b0;
      id_ex.rd_wren  <= 1'b0;
      id_ex.branch   <= 1'b0;
      id_ex.jump     <= 1'b0;
      id_ex.mem_wren <= 1'b0;
      id_ex.mem_rden <= 1'b0;
    end else begin
      id_ex.valid    <= dec_valid;
      id_ex.rd_wren  <= dec_valid && rd_wren;
      id_ex.branch   <= dec_valid && branch;
      id_ex.jump     <= dec_valid && jump;
      id_ex.mem_wren <= dec_valid && mem_wren;
      id_ex.mem_rden <= dec_valid && mem_rden;
    end
  end

  // ID/EX payload
  always_ff @(posedge i_clk) begin
    id_ex.pc        <= i_pc;
    id_ex.rs1_addr  <= rs1;
    id_ex.rs2_addr  <= rs2;
    id_ex.rs1_data  <= rs1_data;
    id_ex.rs2_data  <= rs2_data;
    id_ex.imm       <= imm;
    id_ex.rd        <= rd;
    id_ex.alu_op    <= alu_op;
    id_ex.opa_pc    <= opa_pc;
    id_ex.opb_imm   <= opb_imm;
    id_ex.br_funct3 <= funct3;
    id_ex.wb_sel    <= wb_sel;
  end

endmodule

/* src/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  fwd_sel_e        i_fwd_a,
  input  fwd_sel_e        i_fwd_b,
  id_ex_if.execute        id_ex,
  mem_wb_if.fwd           mem_wb,
  ex_mem_if.execute       ex_mem,
  output logic            o_redirect,
  output logic [XLEN-1:0] o_redirect_pc
);

  logic [XLEN-1:0] src_a;
  logic [XLEN-1:0] src_b;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_out;
  logic [XLEN-1:0] result;
  logic            eq;
  logic            lt;
  logic            br_take;

  function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                              input logic [XLEN-1:0] reg_val,
                                              input logic [XLEN-1:0] mem_val,
                                              input logic [XLEN-1:0] wb_val);
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  // mem-stage value is the ex/mem result field, which also carries the jal link
  assign src_a = fwd_mux(i_fwd_a, id_ex.rs1_data, ex_mem.alu_result, mem_wb.wdata);
  assign src_b = fwd_mux(i_fwd_b, id_ex.rs2_data, ex_mem.alu_result, mem_wb.wdata);

  assign op_a = id_ex.opa_pc ? id_ex.pc : src_a;
  assign op_b = id_ex.opb_imm ? id_ex.imm : src_b;

  always_comb begin
    case (id_ex.alu_op)
      ALU_ADD:    alu_out = op_a + op_b;
      ALU_SUB:    alu_out = op_a - op_b;
      ALU_AND:    alu_out = op_a & op_b;
      ALU_OR:     alu_out = op_a | op_b;
      ALU_XOR:    alu_out = op_a ^ op_b;
      ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_out = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_SLL:    alu_out = op_a << op_b[4:0];
      ALU_SRL:    alu_out = op_a >> op_b[4:0];
      ALU_SRA:    alu_out = $signed(op_a) >>> op_b[4:0];
      ALU_PASS_B: alu_out = op_b;
      default:    alu_out = '0;
    endcase
  end

  // signed branch compare on forwarded registers
  assign eq = src_a == src_b;
  assign lt = $signed(src_a) < $signed(src_b);

  always_comb begin
    case (id_ex.br_funct3)
      3'b000:  br_take = eq;
      3'b001:  br_take = !eq;
      3'b100:  br_take = lt;
      3'b101:  br_take = !lt;
      default: br_take = 1'b0;
    endcase
  end

  assign o_redirect    = id_ex.valid && (id_ex.jump || (id_ex.branch && br_take));
  assign o_redirect_pc = id_ex.pc + id_ex.imm;

  // jal writes back its return address
  assign result = id_ex.jump ? id_ex.pc + XLEN'(4) : alu_out;

  // EX/MEM register
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ex_mem.valid    <= 1'b0;
      ex_mem.rd_wren  <= 1'b0;
      ex_mem.mem_wren <= 1'b0;
      ex_mem.mem_rden <= 1'b0;
    end else begin
      ex_mem.valid    <= id_ex.valid;
      ex_mem.rd_wren  <= id_ex.valid && id_ex.rd_wren;
      ex_mem.mem_wren <= id_ex.valid && id_ex.mem_wren;
      ex_mem.mem_rden <= id_ex.valid && id_ex.mem_rden;
    end
  end

  always_ff @(posedge i_clk) begin
    ex_mem.pc         <= id_ex.pc;
    ex_mem.alu_result <= result;
    ex_mem.store_data <= src_b;
    ex_mem.rd         <= id_ex.rd;
    ex_mem.wb_sel     <= id_ex.wb_sel;
  end

endmodule

/* src/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import rv_pkg::*; #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_imem_wren,
  input  logic [XLEN-1:0] i_imem_addr,
  input  logic [XLEN-1:0] i_imem_wdata,
  input  logic            i_stall,
  input  logic            i_flush,
  input  logic            i_redirect,
  input  logic [XLEN-1:0] i_redirect_pc,
  output logic [XLEN-1:0] o_pc,
  output logic [XLEN-1:0] o_instr,
  output logic            o_valid
);

  localparam int IDX_W = $clog2(IMEM_DEPTH);

  logic [XLEN-1:0] imem [IMEM_DEPTH];
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] instr;

  // redirect wins over a load-use hold
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pc <= '0;
    end else if (i_redirect) begin
      pc <= i_redirect_pc;
    end else if (!i_stall) begin
      pc <= pc + XLEN'(4);
    end
  end

  // word addressed program load port
  always_ff @(posedge i_clk) begin
    if (i_imem_wren) begin
      imem[i_imem_addr[IDX_W-1:0]] <= i_imem_wdata;
    end
  end

  assign instr = imem[pc[IDX_W+1:2]];

  // IF/ID register
  always_ff @(posedge i_clk) begin
    if (!i_rst_n || i_flush) begin
      o_valid <= 1'b0;
    end else if (!i_stall) begin
      o_valid <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_stall) begin
      o_pc    <= pc;
      o_instr <= instr;
    end
  end

endmodule

/* src/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit import rv_pkg::*; (
  input  logic              i_redirect,
  id_ex_if.hazard           id_ex,
  ex_mem_if.hazard          ex_mem,
  mem_wb_if.hazard          mem_wb,
  input  logic [REG_AW-1:0] i_id_rs1,
  input  logic [REG_AW-1:0] i_id_rs2,
  input  logic              i_id_valid,
  output logic              o_stall,
  output logic              o_bubble,
  output logic              o_flush,
  output fwd_sel_e          o_fwd_a,
  output fwd_sel_e          o_fwd_b
);

  logic mem_src;
  logic wb_src;
  logic load_use;

  // nearest producer wins
  function automatic fwd_sel_e fwd_pick(input logic [REG_AW-1:0] rs,
                                        input logic [REG_AW-1:0] mem_rd, input logic mem_en,
                                        input logic [REG_AW-1:0] wb_rd, input logic wb_en);
    if (mem_en && mem_rd == rs) begin
      return FWD_MEM;
    end else if (wb_en && wb_rd == rs) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  // x0 is never a forwarding source
  assign mem_src = ex_mem.valid && ex_mem.rd_wren && ex_mem.rd != '0;
  assign wb_src  = mem_wb.valid && mem_wb.rd_wren && mem_wb.rd != '0;

  assign o_fwd_a = fwd_pick(id_ex.rs1_addr, ex_mem.rd, mem_src, mem_wb.rd, wb_src);
  assign o_fwd_b = fwd_pick(id_ex.rs2_addr, ex_mem.rd, mem_src, mem_wb.rd, wb_src);

  // load in execute feeding the instruction in decode
  assign load_use = i_id_valid && id_ex.mem_rden && id_ex.rd != '0 &&
                    (id_ex.rd == i_id_rs1 || id_ex.rd == i_id_rs2);

  // a taken redirect kills the stalled instruction anyway
  assign o_flush  = i_redirect;
  assign o_stall  = load_use && !i_redirect;
  assign o_bubble = load_use && !i_redirect;

endmodule

/* src/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage import rv_pkg::*; #(
  parameter int DMEM_DEPTH = 256
) (
  input  logic     i_clk,
  input  logic     i_rst_n,
  ex_mem_if.memory ex_mem,
  mem_wb_if.memory mem_wb
);

  localparam int IDX_W = $clog2(DMEM_DEPTH);

  logic [XLEN-1:0]  dmem [DMEM_DEPTH];
  logic [IDX_W-1:0] idx;
  logic [XLEN-1:0]  load_data;
  logic [XLEN-1:0]  wb_data;

  // word index from the byte address
  assign idx = ex_mem.alu_result[IDX_W+1:2];

  always_ff @(posedge i_clk) begin
    if (ex_mem.valid && ex_mem.mem_wren) begin
      dmem[idx] <= ex_mem.store_data;
    end
  end

  assign load_data = ex_mem.mem_rden ? dmem[idx] : '0;

  // alu and pc+4 both arrive in the result field
  always_comb begin
    case (ex_mem.wb_sel)
      WB_LOAD: wb_data = load_data;
      default: wb_data = ex_mem.alu_result;
    endcase
  end

  // MEM/WB register
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      mem_wb.valid   <= 1'b0;
      mem_wb.rd_wren <= 1'b0;
    end else begin
      mem_wb.valid   <= ex_mem.valid;
      mem_wb.rd_wren <= ex_mem.valid && ex_mem.rd_wren;
    end
  end

  always_ff @(posedge i_clk) begin
    mem_wb.pc    <= ex_mem.pc;
    mem_wb.rd    <= ex_mem.rd;
    mem_wb.wdata <= wb_data;
  end

endmodule

/* src/pipe_if.sv */
`timescale 1ns/1ps

// decode to execute
interface id_ex_if import rv_pkg::*; ();
  logic              valid;
  logic [XLEN-1:0]   pc;
  logic [REG_AW-1:0] rs1_addr;
  logic [REG_AW-1:0] rs2_addr;
  logic [XLEN-1:0]   rs1_data;
  logic [XLEN-1:0]   rs2_data;
  logic [XLEN-1:0]   imm;
  logic [REG_AW-1:0] rd;
  logic              rd_wren;
  alu_op_e           alu_op;
  logic              opa_pc;
  logic              opb_imm;
  logic              branch;
  logic [2:0]        br_funct3;
  logic              jump;
  logic              mem_wren;
  logic              mem_rden;
  wb_sel_e           wb_sel;

  modport decode (
    output valid, pc, rs1_addr, rs2_addr, rs1_data, rs2_data, imm, rd, rd_wren,
           alu_op, opa_pc, opb_imm, branch, br_funct3, jump, mem_wren, mem_rden, wb_sel
  );
  modport execute (
    input valid, pc, rs1_data, rs2_data, imm, rd, rd_wren, alu_op, opa_pc, opb_imm,
          branch, br_funct3, jump, mem_wren, mem_rden, wb_sel
  );
  modport hazard (input rs1_addr, rs2_addr, mem_rden, rd);
endinterface

// execute to memory
interface ex_mem_if import rv_pkg::*; ();
  logic              valid;
  logic [XLEN-1:0]   pc;
  logic [XLEN-1:0]   alu_result;
  logic [XLEN-1:0]   store_data;
  logic [REG_AW-1:0] rd;
  logic              rd_wren;
  logic              mem_wren;
  logic              mem_rden;
  wb_sel_e           wb_sel;

  modport execute (
    output valid, pc, alu_result, store_data, rd, rd_wren, mem_wren, mem_rden, wb_sel
  );
  modport memory (
    input valid, pc, alu_result, store_data, rd, rd_wren, mem_wren, mem_rden, wb_sel
  );
  modport hazard (input rd, rd_wren, valid);
endinterface

// memory to writeback
interface mem_wb_if import rv_pkg::*; ();
  logic              valid;
  logic [XLEN-1:0]   pc;
  logic [REG_AW-1:0] rd;
  logic              rd_wren;
  logic [XLEN-1:0]   wdata;

  modport memory (output valid, pc, rd, rd_wren, wdata);
  modport writeback (input rd, rd_wren, wdata);
  modport hazard (input valid, rd, rd_wren);
  modport fwd (input wdata);
endinterface

/* src/regfile.sv */
`timescale 1ns/1ps

module regfile import rv_pkg::*; (
  input  logic              i_clk,
  input  logic [REG_AW-1:0] i_rs1_addr,
  input  logic [REG_AW-1:0] i_rs2_addr,
  input  logic [REG_AW-1:0] i_rd_addr,
  input  logic              i_rd_wren,
  input  logic [XLEN-1:0]   i_rd_data,
  output logic [XLEN-1:0]   o_rs1_data,
  output logic [XLEN-1:0]   o_rs2_data
);

  // x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge i_clk) begin
    if (i_rd_wren && i_rd_addr != '0) begin
      regs[i_rd_addr] <= i_rd_data;
    end
  end

  // same-cycle write is passed straight to the read
  always_comb begin
    if (i_rs1_addr == '0) begin
      o_rs1_data = '0;
    end else if (i_rd_wren && i_rd_addr == i_rs1_addr) begin
      o_rs1_data = i_rd_data;
    end else begin
      o_rs1_data = regs[i_rs1_addr];
    end
  end

  always_comb begin
    if (i_rs2_addr == '0) begin
      o_rs2_data = '0;
    end else if (i_rd_wren && i_rd_addr == i_rs2_addr) begin
      o_rs2_data = i_rd_data;
    end else begin
      o_rs2_data = regs[i_rs2_addr];
    end
  end

endmodule

/* src/rv_core.sv */
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
  parameter int IMEM_DEPTH = 256,
  parameter int DMEM_DEPTH = 256
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_imem_wren,
  input  logic [XLEN-1:0]   i_imem_addr,
  input  logic [XLEN-1:0]   i_imem_wdata,
  output logic              o_wb_valid,
  output logic [XLEN-1:0]   o_wb_pc,
  output logic [REG_AW-1:0] o_wb_rd,
  output logic              o_wb_rd_wren,
  output logic [XLEN-1:0]   o_wb_data
);

  logic [XLEN-1:0] if_pc;
  logic [XLEN-1:0] if_instr;
  logic            if_valid;
  logic            stall;
  logic            bubble;
  logic            flush;
  logic            redirect;
  logic [XLEN-1:0] redirect_pc;
  fwd_sel_e        fwd_a;
  fwd_sel_e        fwd_b;

  id_ex_if  u_id_ex ();
  ex_mem_if u_ex_mem ();
  mem_wb_if u_mem_wb ();

  fetch_stage #(
    .IMEM_DEPTH (IMEM_DEPTH)
  ) u_fetch (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_imem_wren   (i_imem_wren),
    .i_imem_addr   (i_imem_addr),
    .i_imem_wdata  (i_imem_wdata),
    .i_stall       (stall),
    .i_flush       (flush),
    .i_redirect    (redirect),
    .i_redirect_pc (redirect_pc),
    .o_pc          (if_pc),
    .o_instr       (if_instr),
    .o_valid       (if_valid)
  );

  decode_stage u_decode (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_pc     (if_pc),
    .i_instr  (if_instr),
    .i_valid  (if_valid),
    .i_bubble (bubble),
    .i_flush  (flush),
    .id_ex    (u_id_ex.decode),
    .mem_wb   (u_mem_wb.writeback)
  );

  execute_stage u_execute (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_fwd_a       (fwd_a),
    .i_fwd_b       (fwd_b),
    .id_ex         (u_id_ex.execute),
    .mem_wb        (u_mem_wb.fwd),
    .ex_mem        (u_ex_mem.execute),
    .o_redirect    (redirect),
    .o_redirect_pc (redirect_pc)
  );

  memory_stage #(
    .DMEM_DEPTH (DMEM_DEPTH)
  ) u_memory (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .ex_mem  (u_ex_mem.memory),
    .mem_wb  (u_mem_wb.memory)
  );

  hazard_unit u_hazard (
    .i_redirect (redirect),
    .id_ex      (u_id_ex.hazard),
    .ex_mem     (u_ex_mem.hazard),
    .mem_wb     (u_mem_wb.hazard),
    .i_id_rs1   (if_instr[RS1_LSB +: REG_AW]),
    .i_id_rs2   (if_instr[RS2_LSB +: REG_AW]),
    .i_id_valid (if_valid),
    .o_stall    (stall),
    .o_bubble   (bubble),
    .o_flush    (flush),
    .o_fwd_a    (fwd_a),
    .o_fwd_b    (fwd_b)
  );

  // retire port straight off MEM/WB
  assign o_wb_valid   = u_mem_wb.valid;
  assign o_wb_pc      = u_mem_wb.pc;
  assign o_wb_rd      = u_mem_wb.rd;
  assign o_wb_rd_wren = u_mem_wb.rd_wren;
  assign o_wb_data    = u_mem_wb.wdata;

endmodule

/* src/rv_pkg.sv */
package rv_pkg;

  // datapath widths
  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  // instruction field positions
  localparam int OPCODE_LSB = 0;
  localparam int OPCODE_W   = 7;
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int FUNCT3_W   = 3;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int FUNCT7_LSB = 25;
  // funct7 bit that selects sub and sra
  localparam int F7_ALT_BIT = FUNCT7_LSB + 5;

  // major opcodes kept by this core
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_MEM,
    FWD_WB
  } fwd_sel_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_PC4
  } wb_sel_e;

endpackage

/* testbench/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

  localparam int PROG_MAX       = 128;
  localparam int RETIRE_TIMEOUT = 50;
  localparam int MAX_WAITS      = 400;
  localparam int HALT_REPEATS   = 3;

  // major opcodes, straight from the ISA manual
  localparam logic [6:0] OP_R   = 7'b0110011;
  localparam logic [6:0] OP_I   = 7'b0010011;
  localparam logic [6:0] OP_LUI = 7'b0110111;
  localparam logic [6:0] OP_LD  = 7'b0000011;
  localparam logic [6:0] OP_ST  = 7'b0100011;
  localparam logic [6:0] OP_BR  = 7'b1100011;
  localparam logic [6:0] OP_JAL = 7'b1101111;

  typedef enum logic [4:0] {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_SLTU, K_SLL, K_SRL, K_SRA,
    K_ADDI, K_ANDI, K_ORI, K_XORI, K_SLTI, K_SLTIU, K_SLLI, K_SRLI, K_SRAI,
    K_LUI, K_LW, K_SW, K_BEQ, K_BNE, K_BLT, K_BGE, K_JAL
  } kind_e;

  logic        clk;
  logic        rst_n;
  logic        imem_wren;
  logic [31:0] imem_addr;
  logic [31:0] imem_wdata;
  logic        o_wb_valid;
  logic [31:0] o_wb_pc;
  logic [4:0]  o_wb_rd;
  logic        o_wb_rd_wren;
  logic [31:0] o_wb_data;

  // program as records for the model and as words for the DUT
  kind_e       prog_kind [PROG_MAX];
  int          prog_rd   [PROG_MAX];
  int          prog_rs1  [PROG_MAX];
  int          prog_rs2  [PROG_MAX];
  logic [31:0] prog_imm  [PROG_MAX];
  logic [31:0] prog_word [PROG_MAX];
  int          n_instr;
  logic [31:0] halt_pc;
  logic [31:0] rng = 32'h7d81;

  // architectural state of the reference model
  logic [31:0] m_pc;
  logic [31:0] m_regs [32];
  logic [31:0] m_dmem [256];
  int          halt_count;

  logic [31:0] exp_pc;
  logic [31:0] exp_rd;
  logic        exp_wren;
  logic [31:0] exp_data;

  int retired;
  int errors;
  int timeouts;

  rv_core #(
    .IMEM_DEPTH (256),
    .DMEM_DEPTH (256)
  ) u_dut (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_imem_wren  (imem_wren),
    .i_imem_addr  (imem_addr),
    .i_imem_wdata (imem_wdata),
    .o_wb_valid   (o_wb_valid),
    .o_wb_pc      (o_wb_pc),
    .o_wb_rd      (o_wb_rd),
    .o_wb_rd_wren (o_wb_rd_wren),
    .o_wb_data    (o_wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rnd();
    rng = xorshift(rng);
    return rng;
  endfunction

  // random signed 12-bit immediate
  function automatic logic [31:0] imm12();
    logic [31:0] v;
    v = rnd();
    return {{20{v[11]}}, v[11:0]};
  endfunction

  function automatic logic [31:0] encode(input kind_e k, input int rd, input int rs1,
                                         input int rs2, input logic [31:0] imm);
    logic [4:0]  d;
    logic [4:0]  s1;
    logic [4:0]  s2;
    logic [31:0] w;
    d  = rd[4:0];
    s1 = rs1[4:0];
    s2 = rs2[4:0];
    case (k)
      K_ADD:   w = {7'h00, s2, s1, 3'b000, d, OP_R};
      K_SUB:   w = {7'h20, s2, s1, 3'b000, d, OP_R};
      K_SLL:   w = {7'h00, s2, s1, 3'b001, d, OP_R};
      K_SLT:   w = {7'h00, s2, s1, 3'b010, d, OP_R};
      K_SLTU:  w = {7'h00, s2, s1, 3'b011, d, OP_R};
      K_XOR:   w = {7'h00, s2, s1, 3'b100, d, OP_R};
      K_SRL:   w = {7'h00, s2, s1, 3'b101, d, OP_R};
      K_SRA:   w = {7'h20, s2, s1, 3'b101, d, OP_R};
      K_OR:    w = {7'h00, s2, s1, 3'b110, d, OP_R};
      K_AND:   w = {7'h00, s2, s1, 3'b111, d, OP_R};
      K_ADDI:  w = {imm[11:0], s1, 3'b000, d, OP_I};
      K_SLTI:  w = {imm[11:0], s1, 3'b010, d, OP_I};
      K_SLTIU: w = {imm[11:0], s1, 3'b011, d, OP_I};
      K_XORI:  w = {imm[11:0], s1, 3'b100, d, OP_I};
      K_ORI:   w = {imm[11:0], s1, 3'b110, d, OP_I};
      K_ANDI:  w = {imm[11:0], s1, 3'b111, d, OP_I};
      K_SLLI:  w = {7'h00, imm[4:0], s1, 3'b001, d, OP_I};
      K_SRLI:  w = {7'h00, imm[4:0], s1, 3'b101, d, OP_I};
      K_SRAI:  w = {7'h20, imm[4:0], s1, 3'b101, d, OP_I};
      K_LUI:   w = {imm[19:0], d, OP_LUI};
      K_LW:    w = {imm[11:0], s1, 3'b010, d, OP_LD};
      K_SW:    w = {imm[11:5], s2, s1, 3'b010, imm[4:0], OP_ST};
      K_BEQ:   w = {imm[12], imm[10:5], s2, s1, 3'b000, imm[4:1], imm[11], OP_BR};
      K_BNE:   w = {imm[12], imm[10:5], s2, s1, 3'b001, imm[4:1], imm[11], OP_BR};
      K_BLT:   w = {imm[12], imm[10:5], s2, s1, 3'b100, imm[4:1], imm[11], OP_BR};
      K_BGE:   w = {imm[12], imm[10:5], s2, s1, 3'b101, imm[4:1], imm[11], OP_BR};
      K_JAL:   w = {imm[20], imm[10:1], imm[11], imm[19:12], d, OP_JAL};
      default: w = '0;
    endcase
    return w;
  endfunction

  task automatic emit(input kind_e k, input int rd, input int rs1, input int rs2,
                      input logic [31:0] imm);
    prog_kind[n_instr] = k;
    prog_rd[n_instr]   = rd;
    prog_rs1[n_instr]  = rs1;
    prog_rs2[n_instr]  = rs2;
    prog_imm[n_instr]  = imm;
    prog_word[n_instr] = encode(k, rd, rs1, rs2, imm);
    n_instr++;
  endtask

  task automatic build_program();
    logic [31:0] off1;
    logic [31:0] off2;
    n_instr = 0;
    // operand setup
    emit(K_ADDI, 1, 0, 0, imm12());
    emit(K_ADDI, 2, 0, 0, imm12());
    emit(K_LUI, 3, 0, 0, rnd() & 32'h000f_ffff);
    emit(K_ADDI, 4, 0, 0, imm12());
    // independent register-register ops
    emit(K_ADD, 5, 1, 2, 0);
    emit(K_SUB, 6, 1, 2, 0);
    emit(K_AND, 7, 1, 3, 0);
    emit(K_OR, 8, 2, 3, 0);
    emit(K_XOR, 9, 1, 4, 0);
    emit(K_SLT, 10, 1, 2, 0);
    emit(K_SLTU, 11, 2, 1, 0);
    emit(K_SLL, 12, 3, 1, 0);
    emit(K_SRL, 13, 3, 2, 0);
    emit(K_SRA, 14, 3, 1, 0);
    // immediate ops
    emit(K_ADDI, 15, 1, 0, imm12());
    emit(K_ANDI, 16, 2, 0, imm12());
    emit(K_ORI, 17, 3, 0, imm12());
    emit(K_XORI, 18, 4, 0, imm12());
    emit(K_SLTI, 19, 2, 0, imm12());
    emit(K_SLTIU, 20, 1, 0, imm12());
    emit(K_SLLI, 21, 2, 0, rnd() & 32'h1f);
    emit(K_SRLI, 22, 3, 0, rnd() & 32'h1f);
    emit(K_SRAI, 23, 3, 0, rnd() & 32'h1f);
    // dependency chain at distances one, two and three
    emit(K_ADDI, 24, 1, 0, imm12());
    emit(K_ADD, 25, 24, 2, 0);
    emit(K_SUB, 26, 25, 24, 0);
    emit(K_XOR, 27, 24, 26, 0);
    emit(K_OR, 28, 25, 27, 0);
    // store, load back, use at once
    off1 = rnd() & 32'h3c;
    off2 = 32'hffff_fffc - (rnd() & 32'h1c);
    emit(K_ADDI, 29, 0, 0, 256);
    emit(K_SW, 0, 29, 28, off1);
    emit(K_LW, 30, 29, 0, off1);
    emit(K_ADD, 31, 30, 1, 0);
    emit(K_SW, 0, 29, 31, off2);
    emit(K_LW, 5, 29, 0, off2);
    emit(K_SUB, 6, 5, 30, 0);
    // taken branches skip two fillers
    emit(K_ADDI, 7, 0, 0, -5);
    emit(K_ADDI, 8, 0, 0, 3);
    emit(K_ADDI, 9, 0, 0, -5);
    emit(K_BEQ, 0, 7, 9, 12);
    emit(K_ADDI, 10, 0, 0, 32'h111);
    emit(K_ADDI, 10, 0, 0, 32'h222);
    emit(K_BEQ, 0, 7, 8, 12);
    emit(K_ADDI, 10, 0, 0, 32'h333);
    emit(K_BNE, 0, 7, 8, 12);
    emit(K_ADDI, 11, 0, 0, 32'h111);
    emit(K_ADDI, 11, 0, 0, 32'h222);
    emit(K_BNE, 0, 7, 9, 12);
    emit(K_ADDI, 11, 0, 0, 32'h444);
    emit(K_BLT, 0, 7, 8, 12);
    emit(K_ADDI, 12, 0, 0, 32'h111);
    emit(K_ADDI, 12, 0, 0, 32'h222);
    emit(K_BLT, 0, 8, 7, 12);
    emit(K_ADDI, 12, 0, 0, 32'h555);
    emit(K_BGE, 0, 8, 7, 12);
    emit(K_ADDI, 13, 0, 0, 32'h111);
    emit(K_ADDI, 13, 0, 0, 32'h222);
    emit(K_BGE, 0, 7, 8, 12);
    emit(K_ADDI, 13, 0, 0, 32'h666);
    // short countdown loop on a backward branch
    emit(K_ADDI, 3, 0, 0, 3);
    emit(K_ADDI, 3, 3, 0, -1);
    emit(K_BNE, 0, 3, 0, -4);
    // jal over two fillers, then use the link
    emit(K_JAL, 1, 0, 0, 12);
    emit(K_ADDI, 14, 0, 0, 32'h777);
    emit(K_ADDI, 14, 0, 0, 32'h888);
    emit(K_ADD, 2, 1, 0, 0);
    // park on a branch to itself
    halt_pc = 32'(n_instr * 4);
    emit(K_BEQ, 0, 0, 0, 0);
  endtask

  task automatic load_program();
    for (int i = 0; i < n_instr; i++) begin
      @(posedge clk);
      #1;
      imem_wren  = 1'b1;
      imem_addr  = 32'(i);
      imem_wdata = prog_word[i];
    end
    @(posedge clk);
    #1;
    imem_wren = 1'b0;
  endtask

  // executes the next instruction in program order
  task automatic model_step(output bit ok);
    int          idx;
    kind_e       k;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] addr;
    logic [31:0] res;
    logic [31:0] next_pc;
    logic        wr;
    idx = int'(m_pc >> 2);
    ok  = 1'b1;
    if (idx >= n_instr) begin
      $display("model ran past the end of the program at pc %h", m_pc);
      errors++;
      ok = 1'b0;
      return;
    end
    k       = prog_kind[idx];
    a       = m_regs[prog_rs1[idx]];
    b       = m_regs[prog_rs2[idx]];
    imm     = prog_imm[idx];
    addr    = a + imm;
    res     = '0;
    wr      = 1'b1;
    next_pc = m_pc + 32'd4;
    case (k)
      K_ADD:   res = a + b;
      K_SUB:   res = a - b;
      K_AND:   res = a & b;
      K_OR:    res = a | b;
      K_XOR:   res = a ^ b;
      K_SLT:   res = {31'b0, $signed(a) < $signed(b)};
      K_SLTU:  res = {31'b0, a < b};
      K_SLL:   res = a << b[4:0];
      K_SRL:   res = a >> b[4:0];
      K_SRA:   res = $unsigned($signed(a) >>> b[4:0]);
      K_ADDI:  res = a + imm;
      K_ANDI:  res = a & imm;
      K_ORI:   res = a | imm;
      K_XORI:  res = a ^ imm;
      K_SLTI:  res = {31'b0, $signed(a) < $signed(imm)};
      K_SLTIU: res = {31'b0, a < imm};
      K_SLLI:  res = a << imm[4:0];
      K_SRLI:  res = a >> imm[4:0];
      K_SRAI:  res = $unsigned($signed(a) >>> imm[4:0]);
      K_LUI:   res = {imm[19:0], 12'b0};
      K_LW:    res = m_dmem[addr[9:2]];
      K_SW: begin
        wr = 1'b0;
        m_dmem[addr[9:2]] = b;
      end
      K_BEQ: begin
        wr = 1'b0;
        if (a == b) next_pc = m_pc + imm;
      end
      K_BNE: begin
        wr = 1'b0;
        if (a != b) next_pc = m_pc + imm;
      end
      K_BLT: begin
        wr = 1'b0;
        if ($signed(a) < $signed(b)) next_pc = m_pc + imm;
      end
      K_BGE: begin
        wr = 1'b0;
        if ($signed(a) >= $signed(b)) next_pc = m_pc + imm;
      end
      K_JAL: begin
        res     = m_pc + 32'd4;
        next_pc = m_pc + imm;
      end
      default: wr = 1'b0;
    endcase
    exp_pc   = m_pc;
    exp_rd   = prog_rd[idx];
    exp_wren = wr;
    exp_data = res;
    if (wr && prog_rd[idx] != 0) m_regs[prog_rd[idx]] = res;
    if (m_pc == halt_pc) halt_count++;
    m_pc = next_pc;
  endtask

  task automatic check_word(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERR %s expected %h got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      $display("ERR %s expected %h got %h", name, exp, act);
      errors++;
    end
  endtask

  // the registered retire port is stable mid-cycle
  always @(negedge clk) begin
    bit ok;
    if (!rst_n) begin
      check_bit("o_wb_valid", 1'b0, o_wb_valid);
    end else if (o_wb_valid === 1'b1) begin
      if (retired == 0) check_word("o_wb_pc", 32'h0, o_wb_pc);
      model_step(ok);
      if (ok) begin
        check_word("o_wb_pc", exp_pc, o_wb_pc);
        check_bit("o_wb_rd_wren", exp_wren, o_wb_rd_wren);
        // rd and data are don't-care for stores and branches
        if (exp_wren) begin
          check_word("o_wb_rd", exp_rd, {27'b0, o_wb_rd});
          check_word("o_wb_data", exp_data, o_wb_data);
        end
      end
      retired++;
    end
  end

  task automatic wait_retire(output bit ok);
    int start;
    int cycles;
    start  = retired;
    cycles = 0;
    ok     = 1'b0;
    while (!ok && cycles < RETIRE_TIMEOUT) begin
      @(posedge clk);
      cycles++;
      if (retired != start) ok = 1'b1;
    end
  endtask

  initial begin
    bit ok;
    int waits;
    rst_n      = 1'b0;
    imem_wren  = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    m_pc       = '0;
    halt_count = 0;
    retired    = 0;
    errors     = 0;
    timeouts   = 0;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    build_program();
    // core sits in reset while the program goes in
    load_program();
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    ok    = 1'b1;
    waits = 0;
    while (ok && halt_count < HALT_REPEATS && waits < MAX_WAITS) begin
      wait_retire(ok);
      waits++;
    end
    if (!ok) begin
      $display("timed out after %0d cycles without a retired instruction", RETIRE_TIMEOUT);
      timeouts++;
    end else if (halt_count < HALT_REPEATS) begin
      $display("program never settled in its final loop");
      errors++;
    end

    $display("retired %0d, errors %0d, timeouts %0d", retired, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
src/rv_pkg.sv
src/pipe_if.sv
src/regfile.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/hazard_unit.sv
src/rv_core.sv
testbench/tb_rv_core.sv
